//--- verilog/rob_defs.svh
/*
 * Size constants for the reorder buffer.
 * Included by the package and by every module that sizes ports or arrays.
 */

`ifndef ROB_DEFS_SVH
`define ROB_DEFS_SVH

// ----------------------------------------------------------------------
// Pipeline widths
// ----------------------------------------------------------------------
// Instructions accepted from the dispatcher per cycle
`define ROB_DP_NUM        2
// Result bus channels
`define ROB_CDB_NUM       2
// Max instructions retired per cycle
`define ROB_RT_NUM        2

// ----------------------------------------------------------------------
// Storage sizes
// ----------------------------------------------------------------------
// Buffer depth
`define ROB_ENTRY_NUM     8
// Architectural and physical register files
`define ROB_ARCH_REG_NUM  32
`define ROB_PHY_REG_NUM   64

`endif

//--- verilog/rob_pkg.sv
/*
 * Shared types of the reorder buffer: indices, tags, the entry record
 * and the structs that travel on the dispatch, result and retire ports.
 */

`default_nettype none

`include "rob_defs.svh"

package rob_pkg;

    localparam int ROB_IDX_W  = $clog2(`ROB_ENTRY_NUM);
    localparam int TAG_W      = $clog2(`ROB_PHY_REG_NUM);
    localparam int ARCH_W     = $clog2(`ROB_ARCH_REG_NUM);
    localparam int DP_CNT_W   = $clog2(`ROB_DP_NUM + 1);
    localparam int RT_CNT_W   = $clog2(`ROB_RT_NUM + 1);

    typedef logic [ROB_IDX_W-1:0] rob_idx_t;
    typedef logic [TAG_W-1:0]     tag_t;
    typedef logic [ARCH_W-1:0]    arch_reg_t;
    typedef logic [DP_CNT_W-1:0]  dp_cnt_t;
    typedef logic [RT_CNT_W-1:0]  rt_cnt_t;

    // One buffer slot
    typedef struct packed {
        logic      valid;
        logic      complete;
        arch_reg_t rd;
        tag_t      tag;
        tag_t      tag_old;
        logic      br_predict;
        logic      br_result;
    } rob_entry_t;

    // Dispatch request, only the first dp_num slots count
    typedef struct packed {
        dp_cnt_t                         dp_num;
        arch_reg_t [`ROB_DP_NUM-1:0]     rd;
        tag_t      [`ROB_DP_NUM-1:0]     tag;
        tag_t      [`ROB_DP_NUM-1:0]     tag_old;
        logic      [`ROB_DP_NUM-1:0]     br_predict;
    } dp_req_t;

    // Back to the dispatcher
    typedef struct packed {
        dp_cnt_t                     avail_num;
        rob_idx_t [`ROB_DP_NUM-1:0]  rob_idx;
    } dp_resp_t;

    // One result bus channel
    typedef struct packed {
        logic     valid;
        rob_idx_t rob_idx;
        logic     br_result;
    } cdb_t;

    // Map table write per retire slot
    typedef struct packed {
        logic      wr_en;
        arch_reg_t arch_reg;
        tag_t      phy_reg;
    } rt_amt_t;

    // Free list release, first rt_num slots count
    typedef struct packed {
        rt_cnt_t                 rt_num;
        tag_t [`ROB_RT_NUM-1:0]  phy_reg;
    } rt_fl_t;

    // Circular index step, off may not exceed the entry count
    function automatic rob_idx_t rob_idx_add(rob_idx_t base, int unsigned off);
        int unsigned sum;
        sum = int'(base) + off;
        if (sum >= `ROB_ENTRY_NUM) begin
            sum = sum - `ROB_ENTRY_NUM;
        end
        return rob_idx_t'(sum);
    endfunction

endpackage

`default_nettype wire

//--- verilog/rob_ptr.sv
/*
 * Head and tail pointers of the circular buffer.
 * Produces the free-entry count seen by the dispatcher and the indices
 * handed out to this cycle's dispatch slots.
 */

`default_nettype none
`timescale 1ns/1ps

`include "rob_defs.svh"

module rob_ptr (
    input  wire logic             clk_i,
    input  wire logic             rst_i,
    input  wire logic             flush_i,
    input  wire rob_pkg::dp_cnt_t dp_num_i,
    input  wire rob_pkg::rt_cnt_t rt_num_i,
    output rob_pkg::rob_idx_t     head_o,
    output rob_pkg::rob_idx_t     tail_o,
    output rob_pkg::dp_resp_t     dp_resp_o
);
    import rob_pkg::*;

    // Wide enough for entry count plus same-cycle retires
    localparam int CNT_W = $clog2(`ROB_ENTRY_NUM + `ROB_RT_NUM + 1);

    rob_idx_t         head_q;
    rob_idx_t         tail_q;
    logic             head_wrap_q;
    logic             tail_wrap_q;
    logic             head_roll;
    logic             tail_roll;
    logic [CNT_W-1:0] used_num;
    logic [CNT_W-1:0] free_num;

    // ----------------------------------------------------------------------
    // Pointer update
    // ----------------------------------------------------------------------
    // Passing the array end flips the wrap bit
    assign head_roll = (int'(head_q) + int'(rt_num_i)) >= `ROB_ENTRY_NUM;
    assign tail_roll = (int'(tail_q) + int'(dp_num_i)) >= `ROB_ENTRY_NUM;

    always_ff @(posedge clk_i) begin
        if (rst_i || flush_i) begin
            head_q      <= '0;
            tail_q      <= '0;
            head_wrap_q <= 1'b0;
            tail_wrap_q <= 1'b0;
        end else begin
            head_q <= rob_idx_add(head_q, rt_num_i);
            tail_q <= rob_idx_add(tail_q, dp_num_i);
            if (head_roll) begin
                head_wrap_q <= ~head_wrap_q;
            end
            if (tail_roll) begin
                tail_wrap_q <= ~tail_wrap_q;
            end
        end
    end

    assign head_o = head_q;
    assign tail_o = tail_q;

    // ----------------------------------------------------------------------
    // Free count and allocation
    // ----------------------------------------------------------------------
    always_comb begin
        // Same wrap means tail is ahead in the same lap
        if (head_wrap_q == tail_wrap_q) begin
            used_num = CNT_W'(tail_q) - CNT_W'(head_q);
        end else begin
            used_num = CNT_W'(tail_q) + CNT_W'(`ROB_ENTRY_NUM) - CNT_W'(head_q);
        end
        // Entries retiring now are reusable by this dispatch
        free_num = CNT_W'(`ROB_ENTRY_NUM) - used_num + CNT_W'(rt_num_i);
        if (free_num > CNT_W'(`ROB_DP_NUM)) begin
            dp_resp_o.avail_num = dp_cnt_t'(`ROB_DP_NUM);
        end else begin
            dp_resp_o.avail_num = dp_cnt_t'(free_num);
        end
        for (int k = 0; k < `ROB_DP_NUM; k++) begin
            dp_resp_o.rob_idx[k] = rob_idx_add(tail_q, k);
        end
    end

    // Dispatcher keeps within the granted count
    a_dp_within_avail: assert property (@(posedge clk_i) disable iff (rst_i)
        dp_num_i <= dp_resp_o.avail_num);

    // Occupancy never overruns the array
    a_no_overrun: assert property (@(posedge clk_i) disable iff (rst_i)
        used_num <= CNT_W'(`ROB_ENTRY_NUM));

endmodule

`default_nettype wire

//--- verilog/rob_entries.sv
/*
 * Entry storage of the reorder buffer.
 * Writes dispatched instructions at tail, marks result-bus completions
 * and clears retired or flushed entries.
 */

`default_nettype none
`timescale 1ns/1ps

`include "rob_defs.svh"

module rob_entries (
    input  wire logic                                clk_i,
    input  wire logic                                rst_i,
    input  wire logic                                flush_i,
    input  wire rob_pkg::rob_idx_t                   tail_i,
    input  wire rob_pkg::dp_req_t                    dp_req_i,
    input  wire rob_pkg::cdb_t [`ROB_CDB_NUM-1:0]    cdb_i,
    input  wire logic [`ROB_ENTRY_NUM-1:0]           rt_sel_i,
    output rob_pkg::rob_entry_t [`ROB_ENTRY_NUM-1:0] entries_o
);
    import rob_pkg::*;

    // Slot number inside one dispatch group
    localparam int DP_IW = (`ROB_DP_NUM > 1) ? $clog2(`ROB_DP_NUM) : 1;

    // Control bits
    logic [`ROB_ENTRY_NUM-1:0]      valid_q;
    logic [`ROB_ENTRY_NUM-1:0]      complete_q;
    // Payload
    arch_reg_t [`ROB_ENTRY_NUM-1:0] rd_q;
    tag_t [`ROB_ENTRY_NUM-1:0]      tag_q;
    tag_t [`ROB_ENTRY_NUM-1:0]      tag_old_q;
    logic [`ROB_ENTRY_NUM-1:0]      br_predict_q;
    logic [`ROB_ENTRY_NUM-1:0]      br_result_q;

    logic [`ROB_ENTRY_NUM-1:0]      dp_sel;
    logic [DP_IW-1:0]               dp_slot [`ROB_ENTRY_NUM];
    logic [`ROB_ENTRY_NUM-1:0]      cp_sel;
    logic [`ROB_ENTRY_NUM-1:0]      cp_result;

    // ----------------------------------------------------------------------
    // Dispatch window and result-bus match
    // ----------------------------------------------------------------------
    always_comb begin
        rob_idx_t off;
        for (int i = 0; i < `ROB_ENTRY_NUM; i++) begin
            // Distance of this entry past tail, wrapping
            off        = rob_idx_add(rob_idx_t'(i), `ROB_ENTRY_NUM - int'(tail_i));
            dp_sel[i]  = int'(off) < int'(dp_req_i.dp_num);
            dp_slot[i] = DP_IW'(off);
        end
    end

    always_comb begin
        cp_sel    = '0;
        cp_result = '0;
        for (int i = 0; i < `ROB_ENTRY_NUM; i++) begin
            for (int c = 0; c < `ROB_CDB_NUM; c++) begin
                if (cdb_i[c].valid && cdb_i[c].rob_idx == rob_idx_t'(i)) begin
                    cp_sel[i]    = 1'b1;
                    cp_result[i] = cdb_i[c].br_result;
                end
            end
        end
    end

    // ----------------------------------------------------------------------
    // Entry update
    // ----------------------------------------------------------------------
    // Priority is reset, flush, dispatch, retire, complete
    always_ff @(posedge clk_i) begin
        for (int i = 0; i < `ROB_ENTRY_NUM; i++) begin
            if (rst_i || flush_i) begin
                valid_q[i]    <= 1'b0;
                complete_q[i] <= 1'b0;
            end else if (dp_sel[i]) begin
                valid_q[i]    <= 1'b1;
                complete_q[i] <= 1'b0;
            end else if (rt_sel_i[i]) begin
                valid_q[i]    <= 1'b0;
                complete_q[i] <= 1'b0;
            end else if (cp_sel[i] && valid_q[i]) begin
                complete_q[i] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        for (int i = 0; i < `ROB_ENTRY_NUM; i++) begin
            if (dp_sel[i]) begin
                rd_q[i]         <= dp_req_i.rd[dp_slot[i]];
                tag_q[i]        <= dp_req_i.tag[dp_slot[i]];
                tag_old_q[i]    <= dp_req_i.tag_old[dp_slot[i]];
                br_predict_q[i] <= dp_req_i.br_predict[dp_slot[i]];
            end else if (cp_sel[i] && valid_q[i]) begin
                br_result_q[i]  <= cp_result[i];
            end
        end
    end

    always_comb begin
        for (int i = 0; i < `ROB_ENTRY_NUM; i++) begin
            entries_o[i].valid      = valid_q[i];
            entries_o[i].complete   = complete_q[i];
            entries_o[i].rd         = rd_q[i];
            entries_o[i].tag        = tag_q[i];
            entries_o[i].tag_old    = tag_old_q[i];
            entries_o[i].br_predict = br_predict_q[i];
            entries_o[i].br_result  = br_result_q[i];
        end
    end

    // Execution units never report the same entry twice in a cycle
    for (genvar a = 0; a < `ROB_CDB_NUM; a++) begin : g_cdb_a
        for (genvar b = a + 1; b < `ROB_CDB_NUM; b++) begin : g_cdb_b
            a_cdb_distinct: assert property (@(posedge clk_i) disable iff (rst_i)
                !(cdb_i[a].valid && cdb_i[b].valid &&
                  cdb_i[a].rob_idx == cdb_i[b].rob_idx));
        end
    end

endmodule

`default_nettype wire

//--- verilog/rob_retire.sv
/*
 * In-order retire selection.
 * Picks up to ROB_RT_NUM consecutive completed entries from head, detects
 * a retiring mispredicted branch and drives map table and free list.
 */

`default_nettype none
`timescale 1ns/1ps

`include "rob_defs.svh"

module rob_retire (
    input  wire rob_pkg::rob_idx_t                        head_i,
    input  wire rob_pkg::rob_entry_t [`ROB_ENTRY_NUM-1:0] entries_i,
    input  wire logic                                     exception_i,
    output logic [`ROB_ENTRY_NUM-1:0]                     rt_sel_o,
    output rob_pkg::rt_cnt_t                              rt_num_o,
    output logic                                          flush_o,
    output logic                                          br_mis_o,
    output rob_pkg::rt_amt_t [`ROB_RT_NUM-1:0]            rt_amt_o,
    output rob_pkg::rt_fl_t                               rt_fl_o
);
    import rob_pkg::*;

    rob_idx_t [`ROB_RT_NUM-1:0]   win_idx;
    rob_entry_t [`ROB_RT_NUM-1:0] win;
    logic [`ROB_RT_NUM-1:0]       rt_valid;
    logic [`ROB_RT_NUM-1:0]       rt_mis;

    // ----------------------------------------------------------------------
    // Retire window and completion chain
    // ----------------------------------------------------------------------
    always_comb begin
        for (int k = 0; k < `ROB_RT_NUM; k++) begin
            win_idx[k] = rob_idx_add(head_i, k);
            win[k]     = entries_i[win_idx[k]];
        end
    end

    // A slot retires only if every older slot does too
    always_comb begin
        logic chain;
        chain = 1'b1;
        for (int k = 0; k < `ROB_RT_NUM; k++) begin
            chain       = chain & win[k].valid & win[k].complete;
            rt_valid[k] = chain;
        end
    end

    // Thermometer to count
    always_comb begin
        rt_num_o = '0;
        for (int k = 0; k < `ROB_RT_NUM; k++) begin
            if (rt_valid[k]) begin
                rt_num_o = rt_num_o + rt_cnt_t'(1);
            end
        end
    end

    // Back to per-entry select for the storage
    always_comb begin
        rt_sel_o = '0;
        for (int k = 0; k < `ROB_RT_NUM; k++) begin
            if (rt_valid[k]) begin
                rt_sel_o[win_idx[k]] = 1'b1;
            end
        end
    end

    // ----------------------------------------------------------------------
    // Misprediction and flush
    // ----------------------------------------------------------------------
    always_comb begin
        for (int k = 0; k < `ROB_RT_NUM; k++) begin
            rt_mis[k] = rt_valid[k] && (win[k].br_predict != win[k].br_result);
        end
    end

    assign br_mis_o = |rt_mis;
    // Either cause empties the whole buffer
    assign flush_o  = exception_i | br_mis_o;

    // ----------------------------------------------------------------------
    // Map table and free list
    // ----------------------------------------------------------------------
    always_comb begin
        // Free list still sees the count on a flush cycle
        rt_fl_o.rt_num = rt_num_o;
        for (int k = 0; k < `ROB_RT_NUM; k++) begin
            // No map table writes once a mispredict retires
            rt_amt_o[k].wr_en    = rt_valid[k] & ~br_mis_o;
            rt_amt_o[k].arch_reg = win[k].rd;
            rt_amt_o[k].phy_reg  = win[k].tag;
            rt_fl_o.phy_reg[k]   = win[k].tag_old;
        end
    end

endmodule

`default_nettype wire

//--- verilog/rob_top.sv
/*
 * Reorder buffer top level.
 * Connects pointer, storage and retire blocks; all ports are packed
 * structs and carry no handshake.
 */

`default_nettype none
`timescale 1ns/1ps

`include "rob_defs.svh"

module rob_top (
    input  wire logic                             clk_i,
    input  wire logic                             rst_i,
    input  wire rob_pkg::dp_req_t                 dp_req_i,
    output rob_pkg::dp_resp_t                     dp_resp_o,
    input  wire rob_pkg::cdb_t [`ROB_CDB_NUM-1:0] cdb_i,
    input  wire logic                             exception_i,
    output rob_pkg::rt_amt_t [`ROB_RT_NUM-1:0]    rt_amt_o,
    output rob_pkg::rt_fl_t                       rt_fl_o,
    output logic                                  br_mis_o
);
    import rob_pkg::*;

    // Internal nets
    rob_idx_t                         head;
    rob_idx_t                         tail;
    rt_cnt_t                          rt_num;
    logic [`ROB_ENTRY_NUM-1:0]        rt_sel;
    logic                             flush;
    rob_entry_t [`ROB_ENTRY_NUM-1:0]  entries;

    // ----------------------------------------------------------------------
    // Pointers
    // ----------------------------------------------------------------------
    rob_ptr u_ptr (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .flush_i   (flush),
        .dp_num_i  (dp_req_i.dp_num),
        .rt_num_i  (rt_num),
        .head_o    (head),
        .tail_o    (tail),
        .dp_resp_o (dp_resp_o)
    );

    // Entry array
    rob_entries u_entries (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .flush_i   (flush),
        .tail_i    (tail),
        .dp_req_i  (dp_req_i),
        .cdb_i     (cdb_i),
        .rt_sel_i  (rt_sel),
        .entries_o (entries)
    );

    // Retire and flush
    rob_retire u_retire (
        .head_i      (head),
        .entries_i   (entries),
        .exception_i (exception_i),
        .rt_sel_o    (rt_sel),
        .rt_num_o    (rt_num),
        .flush_o     (flush),
        .br_mis_o    (br_mis_o),
        .rt_amt_o    (rt_amt_o),
        .rt_fl_o     (rt_fl_o)
    );

endmodule

`default_nettype wire

//--- test/rob_tb.sv
/*
 * Self-checking testbench for the reorder buffer.
 * A queue model predicts allocation, retire and flush; a checker process
 * compares the DUT against it just before every rising clock edge.
 */

`include "rob_defs.svh"

`default_nettype none
`timescale 1ns/1ps

module rob_tb;
    import rob_pkg::*;

    // One dispatched instruction as the model sees it
    typedef struct packed {
        rob_idx_t  idx;
        arch_reg_t rd;
        tag_t      tag;
        tag_t      tag_old;
        logic      br_predict;
        logic      complete;
        logic      br_result;
    } model_entry_t;

    // Expected retire view for one cycle
    typedef struct packed {
        rt_cnt_t                     rt_num;
        logic                        br_mis;
        logic [`ROB_RT_NUM-1:0]      wr_en;
        arch_reg_t [`ROB_RT_NUM-1:0] rd;
        tag_t [`ROB_RT_NUM-1:0]      tag;
        tag_t [`ROB_RT_NUM-1:0]      tag_old;
    } exp_rt_t;

    logic                           clk;
    logic                           rst;
    dp_req_t                        dp_req;
    dp_resp_t                       dp_resp;
    cdb_t [`ROB_CDB_NUM-1:0]        cdb;
    logic                           exception;
    rt_amt_t [`ROB_RT_NUM-1:0]      rt_amt;
    rt_fl_t                         rt_fl;
    logic                           br_mis;

    // Model state and bookkeeping
    model_entry_t model_q[$];
    rob_idx_t     model_tail;
    int           wrap_cnt;
    int           chk_cnt;
    int           err_cnt;
    int           fail_cnt;

    rob_top u_dut (
        .clk_i       (clk),
        .rst_i       (rst),
        .dp_req_i    (dp_req),
        .dp_resp_o   (dp_resp),
        .cdb_i       (cdb),
        .exception_i (exception),
        .rt_amt_o    (rt_amt),
        .rt_fl_o     (rt_fl),
        .br_mis_o    (br_mis)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ----------------------------------------------------------------------
    // Reference model
    // ----------------------------------------------------------------------
    // Oldest consecutive completed entries, capped at the retire width
    function automatic exp_rt_t exp_retire();
        exp_rt_t e;
        logic    chain;
        e     = '0;
        chain = 1'b1;
        for (int k = 0; k < `ROB_RT_NUM; k++) begin
            if (k < model_q.size()) begin
                chain = chain & model_q[k].complete;
            end else begin
                chain = 1'b0;
            end
            if (chain) begin
                e.rt_num     = e.rt_num + 1'b1;
                e.rd[k]      = model_q[k].rd;
                e.tag[k]     = model_q[k].tag;
                e.tag_old[k] = model_q[k].tag_old;
                if (model_q[k].br_predict != model_q[k].br_result) begin
                    e.br_mis = 1'b1;
                end
            end
        end
        // No map table write in a mispredict cycle
        for (int k = 0; k < `ROB_RT_NUM; k++) begin
            e.wr_en[k] = (k < int'(e.rt_num)) && !e.br_mis;
        end
        return e;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        chk_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("Fail at %0t ns: %s expected %0h, got %0h", $time, name, exp, got);
        end
    endtask

    task automatic compare_outputs(input exp_rt_t e);
        int free_num;
        free_num = `ROB_ENTRY_NUM - model_q.size() + int'(e.rt_num);
        if (free_num > `ROB_DP_NUM) begin
            free_num = `ROB_DP_NUM;
        end
        check_value("dp_resp_o.avail_num", 32'(dp_resp.avail_num), free_num);
        for (int k = 0; k < `ROB_DP_NUM; k++) begin
            check_value($sformatf("dp_resp_o.rob_idx[%0d]", k), 32'(dp_resp.rob_idx[k]),
                        (int'(model_tail) + k) % `ROB_ENTRY_NUM);
        end
        check_value("br_mis_o", 32'(br_mis), 32'(e.br_mis));
        check_value("rt_fl_o.rt_num", 32'(rt_fl.rt_num), 32'(e.rt_num));
        for (int k = 0; k < `ROB_RT_NUM; k++) begin
            check_value($sformatf("rt_amt_o[%0d].wr_en", k), 32'(rt_amt[k].wr_en),
                        32'(e.wr_en[k]));
            // Slot payload only matters when the slot retires
            if (k < int'(e.rt_num)) begin
                check_value($sformatf("rt_amt_o[%0d].arch_reg", k),
                            32'(rt_amt[k].arch_reg), 32'(e.rd[k]));
                check_value($sformatf("rt_amt_o[%0d].phy_reg", k),
                            32'(rt_amt[k].phy_reg), 32'(e.tag[k]));
                check_value($sformatf("rt_fl_o.phy_reg[%0d]", k),
                            32'(rt_fl.phy_reg[k]), 32'(e.tag_old[k]));
            end
        end
    endtask

    // Retire, then completions, then new dispatch, as at the clock edge
    task automatic update_model(input exp_rt_t e);
        model_entry_t ent;
        if (exception || e.br_mis) begin
            model_q.delete();
            model_tail = '0;
        end else begin
            for (int k = 0; k < int'(e.rt_num); k++) begin
                void'(model_q.pop_front());
            end
            for (int c = 0; c < `ROB_CDB_NUM; c++) begin
                if (cdb[c].valid) begin
                    for (int i = 0; i < model_q.size(); i++) begin
                        if (model_q[i].idx == cdb[c].rob_idx) begin
                            ent           = model_q[i];
                            ent.complete  = 1'b1;
                            ent.br_result = cdb[c].br_result;
                            model_q[i]    = ent;
                        end
                    end
                end
            end
            for (int k = 0; k < int'(dp_req.dp_num); k++) begin
                ent.idx        = model_tail;
                ent.rd         = dp_req.rd[k];
                ent.tag        = dp_req.tag[k];
                ent.tag_old    = dp_req.tag_old[k];
                ent.br_predict = dp_req.br_predict[k];
                ent.complete   = 1'b0;
                ent.br_result  = 1'b0;
                model_q.push_back(ent);
                if (int'(model_tail) == `ROB_ENTRY_NUM - 1) begin
                    model_tail = '0;
                    wrap_cnt++;
                end else begin
                    model_tail = model_tail + 1'b1;
                end
            end
        end
    endtask

    // Compare just before each rising edge, inputs settled since +2 ns
    always begin
        exp_rt_t e;
        @(negedge clk);
        #9;
        if (rst) begin
            model_q.delete();
            model_tail = '0;
        end else begin
            e = exp_retire();
            compare_outputs(e);
            update_model(e);
        end
    end

    // ----------------------------------------------------------------------
    // Stimulus helpers
    // ----------------------------------------------------------------------
    // Step to the next cycle with all inputs idle
    task automatic next_cycle();
        @(posedge clk);
        #2;
        dp_req    = '0;
        cdb       = '0;
        exception = 1'b0;
    endtask

    // Slots past n get random junk too
    task automatic set_dispatch(input int n, input logic [`ROB_DP_NUM-1:0] pred);
        dp_req.dp_num = dp_cnt_t'(n);
        for (int k = 0; k < `ROB_DP_NUM; k++) begin
            dp_req.rd[k]         = arch_reg_t'($urandom);
            dp_req.tag[k]        = tag_t'($urandom);
            dp_req.tag_old[k]    = tag_t'($urandom);
            dp_req.br_predict[k] = pred[k];
        end
    endtask

    task automatic set_completion(input int ch, input rob_idx_t idx, input logic res);
        cdb[ch].valid     = 1'b1;
        cdb[ch].rob_idx   = idx;
        cdb[ch].br_result = res;
    endtask

    // Oldest pending entries, correctly predicted
    task automatic complete_oldest();
        int ch;
        ch = 0;
        for (int i = 0; i < model_q.size(); i++) begin
            if (ch < `ROB_CDB_NUM && !model_q[i].complete) begin
                set_completion(ch, model_q[i].idx, model_q[i].br_predict);
                ch++;
            end
        end
    endtask

    // Random pending queue position, -1 if none
    function automatic int pick_pending(input int skip);
        int cands[$];
        for (int i = 0; i < model_q.size(); i++) begin
            if (!model_q[i].complete && i != skip) begin
                cands.push_back(i);
            end
        end
        if (cands.size() == 0) begin
            return -1;
        end
        return cands[$urandom % cands.size()];
    endfunction

    task automatic drain_buffer();
        int cycles;
        cycles = 0;
        while (model_q.size() != 0 && cycles < 60) begin
            next_cycle();
            complete_oldest();
            cycles++;
        end
        if (model_q.size() != 0) begin
            $display("Timeout at %0t ns: buffer did not drain", $time);
            fail_cnt++;
        end
    endtask

    task automatic wait_for_mispredict();
        int cycles;
        cycles = 0;
        while (br_mis !== 1'b1 && cycles < 10) begin
            next_cycle();
            cycles++;
        end
        if (br_mis !== 1'b1) begin
            $display("Timeout at %0t ns: mispredicted branch never retired", $time);
            fail_cnt++;
        end
    endtask

    task automatic check_no_retire(input string when);
        check_value({when, " rt_fl_o.rt_num"}, 32'(rt_fl.rt_num), 0);
        for (int k = 0; k < `ROB_RT_NUM; k++) begin
            check_value($sformatf("%s rt_amt_o[%0d].wr_en", when, k), 32'(rt_amt[k].wr_en), 0);
        end
    endtask

    // ----------------------------------------------------------------------
    // Scenarios
    // ----------------------------------------------------------------------
    task automatic check_after_reset();
        check_value("reset avail_num", 32'(dp_resp.avail_num), `ROB_DP_NUM);
        for (int k = 0; k < `ROB_DP_NUM; k++) begin
            check_value($sformatf("reset rob_idx[%0d]", k), 32'(dp_resp.rob_idx[k]), k);
        end
        check_no_retire("reset");
    endtask

    // Youngest results first, retire must still go oldest first
    task automatic run_in_order();
        next_cycle();
        set_dispatch(2, '0);
        next_cycle();
        set_dispatch(2, '0);
        next_cycle();
        if (model_q.size() < 4) begin
            $display("Dispatch did not reach the buffer before out-of-order completion");
            fail_cnt++;
            return;
        end
        set_completion(0, model_q[3].idx, model_q[3].br_predict);
        set_completion(1, model_q[2].idx, model_q[2].br_predict);
        next_cycle();
        set_completion(0, model_q[1].idx, model_q[1].br_predict);
        next_cycle();
        set_completion(0, model_q[0].idx, model_q[0].br_predict);
        drain_buffer();
    endtask

    task automatic run_fill();
        int cycles;
        int exp_avail;
        cycles = 0;
        next_cycle();
        while (dp_resp.avail_num != 0 && cycles < 20) begin
            set_dispatch(int'(dp_resp.avail_num), '0);
            next_cycle();
            cycles++;
        end
        if (dp_resp.avail_num != 0) begin
            $display("Timeout at %0t ns: buffer never reported full", $time);
            fail_cnt++;
            return;
        end
        complete_oldest();
        next_cycle();
        // Free count is only what retires this cycle
        exp_avail = (`ROB_CDB_NUM < `ROB_RT_NUM) ? `ROB_CDB_NUM : `ROB_RT_NUM;
        if (exp_avail > `ROB_DP_NUM) begin
            exp_avail = `ROB_DP_NUM;
        end
        check_value("full avail_num", 32'(dp_resp.avail_num), exp_avail);
        drain_buffer();
    endtask

    // Odd dispatch count leaves tail off zero, younger entry completes too
    task automatic run_mispredict();
        logic [`ROB_DP_NUM-1:0] pred;
        pred                  = '0;
        pred[`ROB_DP_NUM-1]   = 1'b1;
        next_cycle();
        set_dispatch(2, pred);
        next_cycle();
        set_dispatch(1, '0);
        next_cycle();
        if (model_q.size() < 3) begin
            $display("Dispatch did not reach the buffer before the mispredict");
            fail_cnt++;
            return;
        end
        // Branch in position 1 resolves the other way
        set_completion(0, model_q[1].idx, ~model_q[1].br_predict);
        set_completion(1, model_q[0].idx, model_q[0].br_predict);
        next_cycle();
        set_completion(0, model_q[2].idx, model_q[2].br_predict);
        wait_for_mispredict();
        for (int k = 0; k < `ROB_RT_NUM; k++) begin
            check_value($sformatf("mispredict rt_amt_o[%0d].wr_en", k),
                        32'(rt_amt[k].wr_en), 0);
        end
        next_cycle();
        check_value("after flush avail_num", 32'(dp_resp.avail_num), `ROB_DP_NUM);
        check_value("after flush rob_idx[0]", 32'(dp_resp.rob_idx[0]), 0);
        check_no_retire("after flush");
    endtask

    task automatic run_exception();
        rob_idx_t old_idx;
        next_cycle();
        set_dispatch(2, '0);
        next_cycle();
        set_dispatch(1, '0);
        next_cycle();
        if (model_q.size() < 3) begin
            $display("Dispatch did not reach the buffer before the exception");
            fail_cnt++;
            return;
        end
        old_idx = model_q[0].idx;
        set_completion(0, model_q[1].idx, model_q[1].br_predict);
        set_completion(1, model_q[2].idx, model_q[2].br_predict);
        next_cycle();
        exception = 1'b1;
        next_cycle();
        // Late result for the squashed oldest entry
        set_completion(0, old_idx, 1'b0);
        repeat (3) begin
            next_cycle();
            check_no_retire("after exception");
        end
    endtask

    task automatic run_random(input int cycles);
        int   dp_n;
        int   pick;
        int   first;
        int   wrap_start;
        logic flip;
        wrap_start = wrap_cnt;
        for (int n = 0; n < cycles; n++) begin
            next_cycle();
            dp_n = $urandom % (int'(dp_resp.avail_num) + 1);
            set_dispatch(dp_n, `ROB_DP_NUM'($urandom));
            first = -1;
            for (int ch = 0; ch < `ROB_CDB_NUM; ch++) begin
                pick = pick_pending(first);
                if (pick >= 0 && ($urandom % 10) < 6) begin
                    flip = (($urandom % 20) == 0);
                    set_completion(ch, model_q[pick].idx, model_q[pick].br_predict ^ flip);
                    first = pick;
                end
            end
            exception = (($urandom % 100) == 0);
        end
        if (wrap_cnt - wrap_start < 3) begin
            $display("Random mix wrapped the tail pointer only %0d times",
                     wrap_cnt - wrap_start);
            fail_cnt++;
        end
    endtask

    // ----------------------------------------------------------------------
    // Main sequence
    // ----------------------------------------------------------------------
    initial begin
        void'($urandom(45615));
        rst        = 1'b1;
        dp_req     = '0;
        cdb        = '0;
        exception  = 1'b0;
        model_tail = '0;
        wrap_cnt   = 0;
        chk_cnt    = 0;
        err_cnt    = 0;
        fail_cnt   = 0;
        repeat (2) @(posedge clk);
        #2;
        rst = 1'b0;
        check_after_reset();
        run_in_order();
        if (fail_cnt == 0) begin
            run_fill();
        end
        if (fail_cnt == 0) begin
            run_mispredict();
        end
        if (fail_cnt == 0) begin
            run_exception();
        end
        if (fail_cnt == 0) begin
            run_random(500);
        end
        repeat (3) next_cycle();
        $display("Checks run: %0d, value errors: %0d, other failures: %0d",
                 chk_cnt, err_cnt, fail_cnt);
        if (err_cnt == 0 && fail_cnt == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
+incdir+verilog
verilog/rob_pkg.sv
verilog/rob_ptr.sv
verilog/rob_entries.sv
verilog/rob_retire.sv
verilog/rob_top.sv
test/rob_tb.sv

//--- Makefile
TOP := rob_tb
LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -Wno-fatal -f flist.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -Wno-fatal -f flist.f \
		--top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) 2>&1 | tee $(LOG)
	grep -qx "Simulation passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
